// File: bench/tb_top.sv
////////////////////
// Testbench for the AHB-Lite subsystem. Acts as the bus master and
// checks the RAM, the default slave and the timer with assertions.
////////////////////

`timescale 1ns/100ps

module tb_top
  import ahb_sub_pkg::*;
();

  localparam int MEM_DEPTH = 1024;
  localparam int TIMEOUT   = 4000;  // Cycles well above the test length
  localparam int CMP_N     = 20;    // Compare distance for the flag test

  logic              hclk = 1'b0;
  logic              rst;
  ahb_req_t          req;
  ahb_rsp_t          rsp;
  logic              tint;
  int                errors = 0;
  int                cycles = 0;
  logic [DATA_W-1:0] ram_model [MEM_DEPTH];  // Reference copy of the SRAM
  int                written [$];

  ahb_subsys_top #(
    .MEM_DEPTH ( MEM_DEPTH ) )
  dut0 (
    .hclk_i ( hclk ),
    .rst_i  ( rst  ),
    .req_i  ( req  ),
    .rsp_o  ( rsp  ),
    .tint_o ( tint ) );

  always #2 hclk = ~hclk;

  // Cycle counter and run limit
  always @(posedge hclk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////
  // Helpers
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] ram_addr(input int idx);
    return RAM_BASE + (idx << 2);
  endfunction

  function automatic logic [31:0] reg_addr(input timer_reg_e r);
    return TMR_BASE + {28'h0, r, 2'b00};
  endfunction

  // Expected word after a sized write with AHB lane placement
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input hsize_e size, input logic [1:0] off);
    int          nbytes;
    int          first;
    logic [31:0] res;
    nbytes = (size == SZ_BYTE) ? 1 : ((size == SZ_HALF) ? 2 : 4);
    first  = off & ~(nbytes - 1);
    res    = old_w;
    for (int b = first; b < first + nbytes; b++) begin
      res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  ////////////////////
  // Bus master tasks
  task automatic drive_addr(input logic [31:0] addr, input logic wr, input hsize_e size);
    req.haddr  <= addr;
    req.hwrite <= wr;
    req.hsize  <= size;
    req.htrans <= TR_NONSEQ;
    req.hsel   <= 1'b1;
  endtask

  task automatic wait_ready();
    do begin
      @(negedge hclk);
    end while (rsp.hreadyout !== 1'b1);
  endtask

  task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input hsize_e size,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge hclk);
    drive_addr(addr, wr, size);
    wait_ready();
    @(posedge hclk);
    req.htrans <= TR_IDLE;
    req.hwdata <= wdata;
    wait_ready();                   // Data phase
    rdata = rsp.hrdata;
    check_val("okay_response", 0, rsp.hresp);
  endtask

  task automatic ahb_write(input logic [31:0] addr, input hsize_e size, input logic [31:0] wd);
    logic [31:0] unused;
    ahb_xfer(1'b1, addr, size, wd, unused);
  endtask

  task automatic ahb_read(input logic [31:0] addr, output logic [31:0] rdata);
    ahb_xfer(1'b0, addr, SZ_WORD, '0, rdata);
  endtask

  // Read address phase overlaps the write data phase
  task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata,
                                 output logic [31:0] rdata);
    @(posedge hclk);
    drive_addr(addr, 1'b1, SZ_WORD);
    wait_ready();
    @(posedge hclk);
    drive_addr(addr, 1'b0, SZ_WORD);
    req.hwdata <= wdata;
    wait_ready();
    @(posedge hclk);
    req.htrans <= TR_IDLE;
    wait_ready();
    rdata = rsp.hrdata;
  endtask

  task automatic unmapped_then_read(input logic [31:0] bad_addr, input logic [31:0] ram_a,
                                    output logic [31:0] rdata);
    @(posedge hclk);
    drive_addr(bad_addr, 1'b0, SZ_WORD);
    wait_ready();
    @(posedge hclk);
    drive_addr(ram_a, 1'b0, SZ_WORD);  // Held while the ERROR runs
    @(negedge hclk);
    check_val("error_cycle1_hready", 0, rsp.hreadyout);
    check_val("error_cycle1_hresp", 1, rsp.hresp);
    @(negedge hclk);
    check_val("error_cycle2_hready", 1, rsp.hreadyout);
    check_val("error_cycle2_hresp", 1, rsp.hresp);
    @(posedge hclk);
    req.htrans <= TR_IDLE;
    wait_ready();
    rdata = rsp.hrdata;
    check_val("queued_read_hresp", 0, rsp.hresp);
  endtask

  task automatic read_count(output logic [31:0] cnt, output int at);
    ahb_read(reg_addr(REG_COUNT), cnt);
    at = cycles;
  endtask

  task automatic wait_tint(input logic level, input string name);
    int n;
    n = 0;
    do begin
      @(negedge hclk);
      n++;
    end while (tint !== level && n < 2);
    check_val(name, level, tint);
  endtask

  ////////////////////
  // Test sequence
  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [1:0]  off;
    int          idx;
    int          t1;
    int          t2;
    hsize_e      sz;
    void'($urandom(32'h5269_8cda));
    req        = '0;
    req.htrans = TR_IDLE;
    rst        = 1'b1;
    repeat (16) @(posedge hclk);
    rst <= 1'b0;

    // Idle bus and cleared timer after reset
    @(negedge hclk);
    check_val("reset_hready", 1, rsp.hreadyout);
    check_val("reset_hresp", 0, rsp.hresp);
    check_val("reset_tint", 0, tint);
    for (int r = 0; r < 4; r++) begin
      ahb_read(reg_addr(timer_reg_e'(r)), rd);
      check_val("reset_timer_reg", 0, rd);
    end

    // RAM words and sized writes
    for (int i = 0; i < 32; i++) begin
      idx = $urandom_range(MEM_DEPTH - 1);
      wd  = $urandom;
      ahb_write(ram_addr(idx), SZ_WORD, wd);
      ram_model[idx] = wd;
      written.push_back(idx);
    end
    foreach (written[i]) begin
      ahb_read(ram_addr(written[i]), rd);
      check_val("ram_word", ram_model[written[i]], rd);
    end
    for (int i = 0; i < 12; i++) begin
      idx = written[i];
      sz  = (i % 2) ? SZ_HALF : SZ_BYTE;
      off = (sz == SZ_HALF) ? {1'($urandom_range(1)), 1'b0} : 2'($urandom_range(3));
      wd  = $urandom;
      ahb_write(ram_addr(idx) + off, sz, wd);
      ram_model[idx] = merge_lanes(ram_model[idx], wd, sz, off);
      ahb_read(ram_addr(idx), rd);
      check_val("ram_lanes", ram_model[idx], rd);
    end
    idx = $urandom_range(MEM_DEPTH - 1);
    wd  = $urandom;
    write_then_read(ram_addr(idx), wd, rd);
    ram_model[idx] = wd;
    check_val("back_to_back", ram_model[idx], rd);

    // Default slave and the RAM read queued behind it
    idx = written[0];
    unmapped_then_read(32'h4000_0800, ram_addr(idx), rd);
    check_val("queued_ram_read", ram_model[idx], rd);

    ////////////////////
    // Timer counting with a period of compare plus one
    ahb_write(reg_addr(REG_COMPARE), SZ_WORD, 40);
    ahb_write(reg_addr(REG_CTRL), SZ_WORD, 1);
    read_count(c1, t1);
    read_count(c2, t2);
    check_val("count_bound", 1, (c1 <= 40) && (c2 <= 40));
    check_val("count_step", (c1 + t2 - t1) % 41, c2);
    ahb_write(reg_addr(REG_COUNT), SZ_WORD, 32'h1234);  // Read only
    read_count(c1, t1);
    check_val("count_after_write", (c2 + t1 - t2) % 41, c1);

    // Stopped timer holds its count
    ahb_write(reg_addr(REG_CTRL), SZ_WORD, 0);
    read_count(c1, t1);
    read_count(c2, t2);
    check_val("count_hold", c1, c2);
    ahb_write(reg_addr(REG_STATUS), SZ_WORD, 1);
    ahb_read(reg_addr(REG_STATUS), rd);
    check_val("flag_cleared", 0, rd);

    // Match flag with the interrupt masked
    ahb_write(reg_addr(REG_COMPARE), SZ_WORD, c1 + CMP_N);
    ahb_write(reg_addr(REG_CTRL), SZ_WORD, 1);
    t1 = cycles;
    rd = '0;
    while (rd[0] == 1'b0 && cycles - t1 < 4 * CMP_N) begin
      ahb_read(reg_addr(REG_STATUS), rd);
      check_val("tint_masked", 0, tint);
    end
    check_val("flag_set", 1, rd);
    check_val("flag_latency", 1, (cycles - t1 - 1) <= CMP_N + 2);
    repeat (2) @(negedge hclk);
    check_val("tint_masked_flag_set", 0, tint);  // Flag set and irq_en clear

    // Interrupt raised with the counter stopped and then cleared
    ahb_write(reg_addr(REG_CTRL), SZ_WORD, 2);
    wait_tint(1'b1, "tint_rise");
    ahb_write(reg_addr(REG_STATUS), SZ_WORD, 1);
    wait_tint(1'b0, "tint_fall");
    ahb_read(reg_addr(REG_STATUS), rd);
    check_val("flag_after_clear", 0, rd);

    repeat (2) @(posedge hclk);
    $display("Checks done, %0d error(s)", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: hw/ahb_fabric.sv
////////////////////
// Single-master AHB-Lite fabric. Decodes the address into slave
// selects, tracks the data-phase owner and returns its response.
// Unmapped transfers get a two-cycle ERROR from the default slave.
////////////////////

`timescale 1ns/100ps

module ahb_fabric
  import ahb_sub_pkg::*;
(
  input  logic     hclk_i,
  input  logic     rst_i,
  input  ahb_req_t req_i,
  input  ahb_rsp_t ram_rsp_i,
  input  ahb_rsp_t tmr_rsp_i,
  output logic     ram_sel_o,
  output logic     tmr_sel_o,
  output logic     hready_o,
  output ahb_rsp_t rsp_o
);

  typedef enum logic {
    ERR_IDLE,
    ERR_SECOND
  } err_state_e;

  logic       addr_active;
  logic       accept;
  logic       ram_hit;
  logic       tmr_hit;
  slv_e       dp_slv;       // Owner of the current data phase
  logic       err_pend;     // Unmapped transfer in data phase
  err_state_e err_state;
  ahb_rsp_t   err_rsp;

  ////////////////////
  // Address decode
  assign addr_active = (req_i.htrans == TR_NONSEQ) || (req_i.htrans == TR_SEQ);
  assign ram_hit     = req_i.hsel && ((req_i.haddr & RAM_MASK) == RAM_BASE);
  assign tmr_hit     = req_i.hsel && ((req_i.haddr & TMR_MASK) == TMR_BASE);
  assign ram_sel_o   = ram_hit;
  assign tmr_sel_o   = tmr_hit;
  assign accept      = req_i.hsel && addr_active && hready_o;

  // Data phase owner, moves only while HREADY is high
  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      dp_slv   <= SLV_NONE;
      err_pend <= 1'b0;
    end else if (hready_o) begin
      if (accept && ram_hit) begin
        dp_slv <= SLV_RAM;
      end else if (accept && tmr_hit) begin
        dp_slv <= SLV_TIMER;
      end else begin
        dp_slv <= SLV_NONE;
      end
      err_pend <= accept && !ram_hit && !tmr_hit;
    end
  end

  ////////////////////
  // Default slave
  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      err_state <= ERR_IDLE;
    end else begin
      case (err_state)
        ERR_IDLE: begin
          if (err_pend) begin
            err_state <= ERR_SECOND;
          end
        end
        ERR_SECOND: err_state <= ERR_IDLE;
        default:    err_state <= ERR_IDLE;
      endcase
    end
  end

  // First cycle stalls, second cycle completes
  assign err_rsp.hrdata    = '0;
  assign err_rsp.hreadyout = !(err_pend && (err_state == ERR_IDLE));
  assign err_rsp.hresp     = err_pend;

  // Response mux
  always_comb begin
    case (dp_slv)
      SLV_RAM:   rsp_o = ram_rsp_i;
      SLV_TIMER: rsp_o = tmr_rsp_i;
      default:   rsp_o = err_rsp;
    endcase
  end

  assign hready_o = rsp_o.hreadyout;  // Combined HREADY back to all slaves

endmodule

// File: hw/ahb_sram.sv
////////////////////
// Zero-wait AHB-Lite word SRAM with byte and halfword lane writes.
// MEM_DEPTH is in words and must fit the 4 KB RAM window.
////////////////////

`timescale 1ns/100ps

module ahb_sram
  import ahb_sub_pkg::*;
#(
  parameter int MEM_DEPTH = 1024
) (
  input  logic     hclk_i,
  input  logic     rst_i,
  input  logic     hsel_i,
  input  logic     hready_i,
  input  ahb_req_t req_i,
  output ahb_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  logic [DATA_W-1:0] mem [MEM_DEPTH];

  logic             accept;
  logic [3:0]       lanes;
  logic             dp_wr;     // Write pending in data phase
  logic [IDX_W-1:0] dp_idx;
  logic [3:0]       dp_lanes;

  assign accept = hsel_i && hready_i &&
                  ((req_i.htrans == TR_NONSEQ) || (req_i.htrans == TR_SEQ));

  // Byte lanes from size and low address bits
  always_comb begin
    case (req_i.hsize)
      SZ_BYTE: lanes = 4'b0001 << req_i.haddr[1:0];
      SZ_HALF: lanes = req_i.haddr[1] ? 4'b1100 : 4'b0011;
      default: lanes = 4'b1111;
    endcase
  end

  ////////////////////
  // Address phase capture
  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      dp_wr <= 1'b0;
    end else if (hready_i) begin
      dp_wr <= accept && req_i.hwrite;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (accept) begin
      dp_idx   <= req_i.haddr[IDX_W+1:2];
      dp_lanes <= lanes;
    end
  end

  // Write lands at the end of the data phase
  always_ff @(posedge hclk_i) begin
    if (dp_wr && hready_i) begin
      for (int i = 0; i < 4; i++) begin
        if (dp_lanes[i]) begin
          mem[dp_idx][8*i +: 8] <= req_i.hwdata[8*i +: 8];
        end
      end
    end
  end

  // Full word read, never stalls
  assign rsp_o = '{hrdata: mem[dp_idx], hreadyout: 1'b1, hresp: 1'b0};

endmodule

// File: hw/ahb_sub_pkg.sv
////////////////////
// Shared bus types, address map and timer register layout for the
// AHB-Lite peripheral subsystem. Imported by every RTL block and the
// testbench.
////////////////////

package ahb_sub_pkg;

  ////////////////////
  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // HTRANS encodings, NONSEQ and SEQ carry a transfer
  typedef enum logic [1:0] {
    TR_IDLE   = 2'b00,
    TR_BUSY   = 2'b01,
    TR_NONSEQ = 2'b10,
    TR_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } hsize_e;

  // Master outputs, address phase fields first
  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    logic              hwrite;
    hsize_e            hsize;
    htrans_e           htrans;
    logic [DATA_W-1:0] hwdata;  // Data phase
    logic              hsel;
  } ahb_req_t;

  // One slave response, hresp high is ERROR
  typedef struct packed {
    logic [DATA_W-1:0] hrdata;
    logic              hreadyout;
    logic              hresp;
  } ahb_rsp_t;

  typedef enum logic [1:0] {
    SLV_RAM   = 2'd0,
    SLV_TIMER = 2'd1,
    SLV_NONE  = 2'd2   // Default slave or no transfer
  } slv_e;

  ////////////////////
  // Address map
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK = 32'hFFFF_F000;
  localparam logic [ADDR_W-1:0] TMR_BASE = 32'h4000_0400;
  localparam logic [ADDR_W-1:0] TMR_MASK = 32'hFFFF_FFF0;

  // Timer word offsets, haddr[3:2]
  typedef enum logic [1:0] {
    REG_CTRL    = 2'd0,  // [0] enable, [1] irq enable
    REG_COUNT   = 2'd1,  // Read only
    REG_COMPARE = 2'd2,
    REG_STATUS  = 2'd3   // [0] match flag, write 1 to clear
  } timer_reg_e;

  // Register block to counter
  typedef struct packed {
    logic              enable;
    logic              irq_en;
    logic [DATA_W-1:0] compare;
  } timer_cfg_t;

endpackage

// File: hw/ahb_subsys_top.sv
////////////////////
// AHB-Lite peripheral subsystem. An external master drives req_i;
// the fabric routes it to the SRAM or the timer and tint_o carries
// the timer interrupt.
////////////////////

`timescale 1ns/100ps

module ahb_subsys_top
  import ahb_sub_pkg::*;
#(
  parameter int MEM_DEPTH = 1024  // Words, at most 1024
) (
  input  logic     hclk_i,
  input  logic     rst_i,
  input  ahb_req_t req_i,
  output ahb_rsp_t rsp_o,
  output logic     tint_o
);

  logic              hready;     // Combined HREADY to every slave
  logic              ram_sel;
  logic              tmr_sel;
  ahb_rsp_t          ram_rsp;
  ahb_rsp_t          tmr_rsp;
  timer_cfg_t        tmr_cfg;
  logic              flag_clr;
  logic [DATA_W-1:0] tmr_count;
  logic              tmr_flag;

  ////////////////////
  // Fabric and slaves
  ahb_fabric fabric0 (
    .hclk_i    ( hclk_i  ),
    .rst_i     ( rst_i   ),
    .req_i     ( req_i   ),
    .ram_rsp_i ( ram_rsp ),
    .tmr_rsp_i ( tmr_rsp ),
    .ram_sel_o ( ram_sel ),
    .tmr_sel_o ( tmr_sel ),
    .hready_o  ( hready  ),
    .rsp_o     ( rsp_o   ) );

  ahb_sram #(
    .MEM_DEPTH ( MEM_DEPTH ) )
  ram0 (
    .hclk_i    ( hclk_i  ),
    .rst_i     ( rst_i   ),
    .hsel_i    ( ram_sel ),
    .hready_i  ( hready  ),
    .req_i     ( req_i   ),
    .rsp_o     ( ram_rsp ) );

  timer_regs tregs0 (
    .hclk_i     ( hclk_i    ),
    .rst_i      ( rst_i     ),
    .hsel_i     ( tmr_sel   ),
    .hready_i   ( hready    ),
    .req_i      ( req_i     ),
    .count_i    ( tmr_count ),
    .flag_i     ( tmr_flag  ),
    .rsp_o      ( tmr_rsp   ),
    .cfg_o      ( tmr_cfg   ),
    .flag_clr_o ( flag_clr  ) );

  timer_core tcore0 (
    .hclk_i     ( hclk_i    ),
    .rst_i      ( rst_i     ),
    .cfg_i      ( tmr_cfg   ),
    .flag_clr_i ( flag_clr  ),
    .count_o    ( tmr_count ),
    .flag_o     ( tmr_flag  ),
    .tint_o     ( tint_o    ) );  // Timer interrupt

endmodule

// File: hw/timer_core.sv
////////////////////
// Timer counter. Counts while enabled, wraps to zero on a compare
// match and sets a sticky flag that drives the interrupt line.
////////////////////

`timescale 1ns/100ps

module timer_core
  import ahb_sub_pkg::*;
(
  input  logic              hclk_i,
  input  logic              rst_i,
  input  timer_cfg_t        cfg_i,
  input  logic              flag_clr_i,
  output logic [DATA_W-1:0] count_o,
  output logic              flag_o,
  output logic              tint_o
);

  logic              match;
  logic [DATA_W-1:0] count_q;
  logic              flag_q;

  assign match = cfg_i.enable && (count_q == cfg_i.compare);

  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      count_q <= '0;
      flag_q  <= 1'b0;
      tint_o  <= 1'b0;
    end else begin
      if (cfg_i.enable) begin
        count_q <= match ? '0 : count_q + 1'b1;
      end

      // Match wins over a clear in the same cycle
      if (match) begin
        flag_q <= 1'b1;
      end else if (flag_clr_i) begin
        flag_q <= 1'b0;
      end

      tint_o <= flag_q && cfg_i.irq_en;  // One cycle behind the flag
    end
  end

  assign count_o = count_q;
  assign flag_o  = flag_q;

endmodule

// File: hw/timer_regs.sv
////////////////////
// AHB-Lite register block of the timer. Holds CTRL and COMPARE,
// reads back the live count and the match flag, and turns a STATUS
// write of 1 into a one-cycle clear strobe for the counter.
////////////////////

`timescale 1ns/100ps

module timer_regs
  import ahb_sub_pkg::*;
(
  input  logic              hclk_i,
  input  logic              rst_i,
  input  logic              hsel_i,
  input  logic              hready_i,
  input  ahb_req_t          req_i,
  input  logic [DATA_W-1:0] count_i,
  input  logic              flag_i,
  output ahb_rsp_t          rsp_o,
  output timer_cfg_t        cfg_o,
  output logic              flag_clr_o
);

  logic              accept;
  logic              dp_wr;
  timer_reg_e        dp_reg;
  logic              wr_en;
  timer_cfg_t        cfg_q;
  logic [DATA_W-1:0] rdata;

  assign accept = hsel_i && hready_i &&
                  ((req_i.htrans == TR_NONSEQ) || (req_i.htrans == TR_SEQ));

  ////////////////////
  // Address phase capture
  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      dp_wr  <= 1'b0;
      dp_reg <= REG_CTRL;
    end else if (hready_i) begin
      dp_wr <= accept && req_i.hwrite;
      if (accept) begin
        dp_reg <= timer_reg_e'(req_i.haddr[3:2]);
      end
    end
  end

  assign wr_en = dp_wr && hready_i;  // Last cycle of a write data phase

  // COUNT and STATUS are not stored here
  always_ff @(posedge hclk_i) begin
    if (rst_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (dp_reg)
        REG_CTRL: begin
          cfg_q.enable <= req_i.hwdata[0];
          cfg_q.irq_en <= req_i.hwdata[1];
        end
        REG_COMPARE: cfg_q.compare <= req_i.hwdata;
        default: begin
        end
      endcase
    end
  end

  assign flag_clr_o = wr_en && (dp_reg == REG_STATUS) && req_i.hwdata[0];
  assign cfg_o      = cfg_q;

  ////////////////////
  // Read back
  always_comb begin
    case (dp_reg)
      REG_CTRL:    rdata = {{(DATA_W-2){1'b0}}, cfg_q.irq_en, cfg_q.enable};
      REG_COUNT:   rdata = count_i;
      REG_COMPARE: rdata = cfg_q.compare;
      REG_STATUS:  rdata = {{(DATA_W-1){1'b0}}, flag_i};
      default:     rdata = '0;
    endcase
  end

  assign rsp_o = '{hrdata: rdata, hreadyout: 1'b1, hresp: 1'b0};

endmodule

// File: tb.f
hw/ahb_sub_pkg.sv
hw/ahb_fabric.sv
hw/ahb_sram.sv
hw/timer_regs.sv
hw/timer_core.sv
hw/ahb_subsys_top.sv
bench/tb_top.sv
